// File: Makefile
TOP := tb_axi_sram

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing -f filelist.f --top-module axi_sram_top

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+rtl
rtl/axi_sram_pkg.sv
rtl/sram_if.sv
rtl/burst_addr_counter.sv
rtl/axi_slave_fsm.sv
rtl/sram_array.sv
rtl/resp_slice.sv
rtl/axi_sram_top.sv
sim/tb_axi_sram.sv

// File: rtl/axi_slave_fsm.sv
// AXI slave control: read and write channel FSMs, SRAM port arbitration and responses
`timescale 1ns/10ps
`include "axi_sram_cfg.svh"

module axi_slave_fsm
  import axi_sram_pkg::*;
(
  input  logic                   i_aclk,
  input  logic                   i_rst_n,
  input  logic [`AXI_ID_W-1:0]   i_awid,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  logic [`AXI_DATA_W-1:0] i_wdata,
  input  logic [`AXI_STRB_W-1:0] i_wstrb,
  input  logic                   i_wlast,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  input  logic [`AXI_ID_W-1:0]   i_arid,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output logic                   o_wr_load,
  output logic                   o_wr_step,
  input  logic [`SRAM_AW-1:0]    i_wr_word,
  input  logic                   i_wr_last,
  input  logic                   i_wr_bad,
  output logic                   o_rd_load,
  output logic                   o_rd_step,
  input  logic [`SRAM_AW-1:0]    i_rd_word,
  input  logic                   i_rd_last,
  input  logic                   i_rd_bad,
  sram_if.ctrl                   sram,
  output logic                   o_r_valid,
  input  logic                   i_r_ready,
  output r_beat_t                o_r_beat,
  output logic                   o_b_valid,
  input  logic                   i_b_ready,
  output b_beat_t                o_b_beat
);

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_WAIT, RD_HOLD} rd_state_e;

  wr_state_e            wr_state_q;
  rd_state_e            rd_state_q;
  logic [`AXI_ID_W-1:0] bid_q;
  logic [`AXI_ID_W-1:0] rid_q;
  logic                 wr_err_q;
  logic                 aw_fire;
  logic                 w_fire;
  logic                 ar_fire;
  logic                 wr_beat_bad;
  logic                 wr_en;
  logic                 rd_issue;
  logic                 rd_present;
  logic                 r_push;

  assign o_awready = (wr_state_q == WR_IDLE);
  // B slice is always empty here, the term only guards the push
  assign o_wready  = (wr_state_q == WR_DATA) && i_b_ready;
  assign o_arready = (rd_state_q == RD_IDLE);

  assign aw_fire = i_awvalid && o_awready;
  assign w_fire  = i_wvalid && o_wready;
  assign ar_fire = i_arvalid && o_arready;

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------
  // Out of range, WRAP, or wlast off the counted last beat
  assign wr_beat_bad = i_wr_bad || (i_wlast != i_wr_last);
  assign wr_en       = w_fire && !wr_beat_bad && !wr_err_q;
  assign o_wr_load   = aw_fire;
  assign o_wr_step   = w_fire;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_state_q <= WR_IDLE;
      wr_err_q   <= 1'b0;
    end else begin
      case (wr_state_q)
        WR_IDLE: begin
          if (aw_fire) begin
            wr_state_q <= WR_DATA;
            wr_err_q   <= 1'b0;
          end
        end
        WR_DATA: begin
          if (w_fire && wr_beat_bad) begin
            wr_err_q <= 1'b1;
          end
          if (w_fire && i_wlast) begin
            wr_state_q <= WR_RESP;
          end
        end
        // Slice holds the response, leave once it is taken
        WR_RESP: begin
          if (i_b_ready) begin
            wr_state_q <= WR_IDLE;
          end
        end
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      bid_q <= i_awid;
    end
  end

  assign o_b_valid     = w_fire && i_wlast;
  assign o_b_beat.id   = bid_q;
  assign o_b_beat.resp = (wr_err_q || wr_beat_bad) ? RESP_SLVERR : RESP_OKAY;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  // Write beats win the port, a read issue retries next cycle
  assign rd_issue   = (rd_state_q == RD_ISSUE) && !i_rd_bad && !wr_en;
  assign rd_present = (rd_state_q == RD_WAIT) || (rd_state_q == RD_HOLD);
  assign r_push     = rd_present && i_r_ready;
  assign o_rd_load  = ar_fire;
  assign o_rd_step  = r_push && !i_rd_last;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      rd_state_q <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: begin
          if (ar_fire) begin
            rd_state_q <= RD_ISSUE;
          end
        end
        // Bad beats skip the memory entirely
        RD_ISSUE: begin
          if (i_rd_bad || !wr_en) begin
            rd_state_q <= RD_WAIT;
          end
        end
        RD_WAIT, RD_HOLD: begin
          if (i_r_ready) begin
            rd_state_q <= i_rd_last ? RD_IDLE : RD_ISSUE;
          end else begin
            rd_state_q <= RD_HOLD;
          end
        end
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rid_q <= i_arid;
    end
  end

  // Array output stays put until the next read, so HOLD can re-present it
  assign o_r_valid     = rd_present;
  assign o_r_beat.id   = rid_q;
  assign o_r_beat.data = i_rd_bad ? '0 : sram.rdata;
  assign o_r_beat.resp = i_rd_bad ? RESP_SLVERR : RESP_OKAY;
  assign o_r_beat.last = i_rd_last;

  // --------------------------------------------------
  // SRAM port
  // --------------------------------------------------
  assign sram.en    = wr_en || rd_issue;
  assign sram.we    = wr_en;
  assign sram.addr  = wr_en ? i_wr_word : i_rd_word;
  assign sram.wdata = i_wdata;
  assign sram.wstrb = i_wstrb;

endmodule

// File: rtl/axi_sram_cfg.svh
// AXI SRAM slave configuration: bus widths, ID width and memory depth
`ifndef AXI_SRAM_CFG_SVH
`define AXI_SRAM_CFG_SVH

// --------------------------------------------------
// AXI bus
// --------------------------------------------------
`define AXI_DATA_W 64
`define AXI_STRB_W (`AXI_DATA_W/8)
`define AXI_ADDR_W 32
`define AXI_ID_W 4

// --------------------------------------------------
// SRAM geometry
// --------------------------------------------------
// Depth in bus-wide words
`define SRAM_DEPTH 1024
// Word index width, log2 of the depth
`define SRAM_AW 10

`endif

// File: rtl/axi_sram_pkg.sv
// AXI SRAM slave types: burst and response encodings, R and B channel beats
`include "axi_sram_cfg.svh"

package axi_sram_pkg;

  // Burst type encoding from the AXI spec
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // One read data beat, 71 bits
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    axi_resp_e              resp;
    logic                   last;
  } r_beat_t;

  // One write response, 6 bits
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    axi_resp_e            resp;
  } b_beat_t;

endpackage

// File: rtl/axi_sram_top.sv
// AXI4 slave around an on-chip SRAM with FIXED and INCR burst support
`timescale 1ns/10ps
`include "axi_sram_cfg.svh"

module axi_sram_top
  import axi_sram_pkg::*;
(
  input  logic                   i_aclk,
  input  logic                   i_rst_n,
  // Write address
  input  logic [`AXI_ID_W-1:0]   i_awid,
  input  logic [`AXI_ADDR_W-1:0] i_awaddr,
  input  logic [7:0]             i_awlen,
  input  logic [2:0]             i_awsize,
  input  logic [1:0]             i_awburst,
  input  logic                   i_awlock,
  input  logic [3:0]             i_awcache,
  input  logic [2:0]             i_awprot,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  // Write data
  input  logic [`AXI_DATA_W-1:0] i_wdata,
  input  logic [`AXI_STRB_W-1:0] i_wstrb,
  input  logic                   i_wlast,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  // Write response
  output logic [`AXI_ID_W-1:0]   o_bid,
  output logic [1:0]             o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  // Read address
  input  logic [`AXI_ID_W-1:0]   i_arid,
  input  logic [`AXI_ADDR_W-1:0] i_araddr,
  input  logic [7:0]             i_arlen,
  input  logic [2:0]             i_arsize,
  input  logic [1:0]             i_arburst,
  input  logic                   i_arlock,
  input  logic [3:0]             i_arcache,
  input  logic [2:0]             i_arprot,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  // Read data
  output logic [`AXI_ID_W-1:0]   o_rid,
  output logic [`AXI_DATA_W-1:0] o_rdata,
  output logic [1:0]             o_rresp,
  output logic                   o_rlast,
  output logic                   o_rvalid,
  input  logic                   i_rready
);

  // Lock, cache and prot stop here, the slave ignores them

  logic                wr_load;
  logic                wr_step;
  logic [`SRAM_AW-1:0] wr_word;
  logic                wr_last;
  logic                wr_bad;
  logic                rd_load;
  logic                rd_step;
  logic [`SRAM_AW-1:0] rd_word;
  logic                rd_last;
  logic                rd_bad;
  logic                r_valid;
  logic                r_ready;
  r_beat_t             r_beat;
  r_beat_t             r_out;
  logic                b_valid;
  logic                b_ready;
  b_beat_t             b_beat;
  b_beat_t             b_out;

  sram_if sram_bus ();

  // --------------------------------------------------
  // Control and address tracking
  // --------------------------------------------------
  axi_slave_fsm u_fsm (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awid    (i_awid),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wlast   (i_wlast),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_arid    (i_arid),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_wr_load (wr_load),
    .o_wr_step (wr_step),
    .i_wr_word (wr_word),
    .i_wr_last (wr_last),
    .i_wr_bad  (wr_bad),
    .o_rd_load (rd_load),
    .o_rd_step (rd_step),
    .i_rd_word (rd_word),
    .i_rd_last (rd_last),
    .i_rd_bad  (rd_bad),
    .sram      (sram_bus.ctrl),
    .o_r_valid (r_valid),
    .i_r_ready (r_ready),
    .o_r_beat  (r_beat),
    .o_b_valid (b_valid),
    .i_b_ready (b_ready),
    .o_b_beat  (b_beat)
  );

  burst_addr_counter u_wr_cnt (
    .i_aclk  (i_aclk),
    .i_rst_n (i_rst_n),
    .i_load  (wr_load),
    .i_step  (wr_step),
    .i_addr  (i_awaddr),
    .i_len   (i_awlen),
    .i_size  (i_awsize),
    .i_burst (i_awburst),
    .o_word  (wr_word),
    .o_last  (wr_last),
    .o_bad   (wr_bad)
  );

  burst_addr_counter u_rd_cnt (
    .i_aclk  (i_aclk),
    .i_rst_n (i_rst_n),
    .i_load  (rd_load),
    .i_step  (rd_step),
    .i_addr  (i_araddr),
    .i_len   (i_arlen),
    .i_size  (i_arsize),
    .i_burst (i_arburst),
    .o_word  (rd_word),
    .o_last  (rd_last),
    .o_bad   (rd_bad)
  );

  sram_array u_sram (
    .i_aclk (i_aclk),
    .mem    (sram_bus.mem)
  );

  // --------------------------------------------------
  // Response output registers
  // --------------------------------------------------
  resp_slice #(.payload_t(r_beat_t)) u_r_slice (
    .i_aclk  (i_aclk),
    .i_rst_n (i_rst_n),
    .i_valid (r_valid),
    .o_ready (r_ready),
    .i_data  (r_beat),
    .o_valid (o_rvalid),
    .i_ready (i_rready),
    .o_data  (r_out)
  );

  resp_slice #(.payload_t(b_beat_t)) u_b_slice (
    .i_aclk  (i_aclk),
    .i_rst_n (i_rst_n),
    .i_valid (b_valid),
    .o_ready (b_ready),
    .i_data  (b_beat),
    .o_valid (o_bvalid),
    .i_ready (i_bready),
    .o_data  (b_out)
  );

  assign o_rid   = r_out.id;
  assign o_rdata = r_out.data;
  assign o_rresp = r_out.resp;
  assign o_rlast = r_out.last;
  assign o_bid   = b_out.id;
  assign o_bresp = b_out.resp;

endmodule

// File: rtl/burst_addr_counter.sv
// Burst address counter: tracks one burst's address, beat count, last beat and range errors
`timescale 1ns/10ps
`include "axi_sram_cfg.svh"

module burst_addr_counter
  import axi_sram_pkg::*;
(
  input  logic                  i_aclk,
  input  logic                  i_rst_n,
  input  logic                  i_load,
  input  logic                  i_step,
  input  logic [`AXI_ADDR_W-1:0] i_addr,
  input  logic [7:0]            i_len,
  input  logic [2:0]            i_size,
  input  logic [1:0]            i_burst,
  output logic [`SRAM_AW-1:0]   o_word,
  output logic                  o_last,
  output logic                  o_bad
);

  // Byte offset bits inside one bus word
  localparam int WORD_OFS = $clog2(`AXI_STRB_W);

  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [2:0]             size_q;
  logic [1:0]             burst_q;
  // Beats left after the current one
  logic [7:0]             cnt_q;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      cnt_q   <= '0;
      burst_q <= BURST_INCR;
    end else if (i_load) begin
      cnt_q   <= i_len;
      burst_q <= i_burst;
    end else if (i_step) begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_load) begin
      addr_q <= i_addr;
      size_q <= i_size;
    end else if (i_step && (burst_q == BURST_INCR)) begin
      // FIXED keeps the address, INCR moves by the transfer size
      addr_q <= addr_q + (`AXI_ADDR_W'(1) << size_q);
    end
  end

  assign o_word = addr_q[`SRAM_AW+WORD_OFS-1:WORD_OFS];
  assign o_last = (cnt_q == 8'd0);

  // WRAP and the reserved encoding are both refused
  assign o_bad = ((burst_q != BURST_FIXED) && (burst_q != BURST_INCR)) ||
                 (addr_q[`AXI_ADDR_W-1:WORD_OFS] >=
                  (`AXI_ADDR_W-WORD_OFS)'(`SRAM_DEPTH));

endmodule

// File: rtl/resp_slice.sv
// One-entry valid/ready register slice for response channel beats
`timescale 1ns/10ps

module resp_slice #(
  parameter type payload_t = logic
) (
  input  logic     i_aclk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data
);

  logic     full_q;
  payload_t data_q;
  logic     push;

  // Accept when empty or when the held item leaves this cycle
  assign o_ready = !full_q || i_ready;
  assign push    = i_valid && o_ready;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (i_ready) begin
      full_q <= 1'b0;
    end
  end

  // Content changes only on a push, so it is stable under back-pressure
  always_ff @(posedge i_aclk) begin
    if (push) begin
      data_q <= i_data;
    end
  end

  assign o_valid = full_q;
  assign o_data  = data_q;

endmodule

// File: rtl/sram_array.sv
// Single-port synchronous SRAM with byte write enables and one-cycle read
`timescale 1ns/10ps
`include "axi_sram_cfg.svh"

module sram_array (
  input  logic i_aclk,
  sram_if.mem  mem
);

  logic [`AXI_DATA_W-1:0] mem_q [`SRAM_DEPTH];
  logic [`AXI_DATA_W-1:0] rdata_q;

  // Byte lanes written only where the strobe is set
  always_ff @(posedge i_aclk) begin
    if (mem.en && mem.we) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (mem.wstrb[b]) begin
          mem_q[mem.addr][8*b +: 8] <= mem.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read register only loads on a read, it holds across writes
  always_ff @(posedge i_aclk) begin
    if (mem.en && !mem.we) begin
      rdata_q <= mem_q[mem.addr];
    end
  end

  assign mem.rdata = rdata_q;

endmodule

// File: rtl/sram_if.sv
// Single SRAM port between the AXI controller and the memory array
`timescale 1ns/10ps
`include "axi_sram_cfg.svh"

interface sram_if;

  logic                   en;
  logic                   we;
  // Word index, not a byte address
  logic [`SRAM_AW-1:0]    addr;
  logic [`AXI_DATA_W-1:0] wdata;
  logic [`AXI_STRB_W-1:0] wstrb;
  // Valid one cycle after a read request
  logic [`AXI_DATA_W-1:0] rdata;

  modport ctrl (
    output en,
    output we,
    output addr,
    output wdata,
    output wstrb,
    input  rdata
  );

  modport mem (
    input  en,
    input  we,
    input  addr,
    input  wdata,
    input  wstrb,
    output rdata
  );

endinterface

// File: sim/tb_axi_sram.sv
// Testbench for the AXI4 SRAM slave: burst traffic, byte model and protocol assertions
`timescale 1ns/10ps
`include "axi_sram_cfg.svh"

module tb_axi_sram
  import axi_sram_pkg::*;
;

  // Tests take about a thousand cycles, the limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MODEL_AW       = 13;

  logic                   i_aclk = 1'b0;
  logic                   i_rst_n;
  logic [`AXI_ID_W-1:0]   i_awid, i_arid;
  logic [`AXI_ADDR_W-1:0] i_awaddr, i_araddr;
  logic [7:0]             i_awlen, i_arlen;
  logic [2:0]             i_awsize, i_arsize, i_awprot, i_arprot;
  logic [1:0]             i_awburst, i_arburst;
  logic                   i_awlock, i_arlock;
  logic [3:0]             i_awcache, i_arcache;
  logic                   i_awvalid, i_arvalid, o_awready, o_arready;
  logic [`AXI_DATA_W-1:0] i_wdata;
  logic [`AXI_STRB_W-1:0] i_wstrb;
  logic                   i_wlast, i_wvalid, o_wready;
  logic [`AXI_ID_W-1:0]   o_bid, o_rid;
  logic [1:0]             o_bresp, o_rresp;
  logic                   o_bvalid, i_bready;
  logic [`AXI_DATA_W-1:0] o_rdata;
  logic                   o_rlast, o_rvalid, i_rready;

  // Reference model and expected responses
  logic [7:0]             model_mem [`SRAM_DEPTH*`AXI_STRB_W];
  logic [`AXI_DATA_W-1:0] wr_data [256];
  logic [`AXI_STRB_W-1:0] wr_strb [256];
  logic [`AXI_DATA_W-1:0] exp_r_data [256];
  logic [`AXI_DATA_W-1:0] exp_rdata;
  logic                   exp_rlast;
  logic [`AXI_ID_W-1:0]   exp_rid = '0;
  logic [`AXI_ID_W-1:0]   exp_bid = '0;
  logic [1:0]             exp_rresp = RESP_OKAY;
  logic [1:0]             exp_bresp = RESP_OKAY;
  logic [`AXI_DATA_W-1:0] prev_rdata;
  logic [1:0]             prev_bresp;
  int                     r_seen = 0;
  int                     b_seen = 0;
  int                     r_base = 0;
  int                     r_len = 0;
  int                     cycle_cnt = 0;
  int                     err_cnt = 0;
  int                     err_at_start = 0;
  int                     test_cnt = 0;
  int                     failed_tests = 0;
  bit                     rand_ready = 1'b0;

  axi_sram_top dut_i (.*);

  always #4 i_aclk = ~i_aclk;

  assign exp_rdata = exp_r_data[8'(r_seen - r_base)];
  assign exp_rlast = ((r_seen - r_base) == r_len);

  // Beat counters and one-cycle history for the stability checks
  always @(posedge i_aclk) begin
    if (!i_rst_n) begin
      r_seen <= 0;
      b_seen <= 0;
    end else begin
      if (o_rvalid && i_rready) begin
        r_seen <= r_seen + 1;
      end
      if (o_bvalid && i_bready) begin
        b_seen <= b_seen + 1;
      end
    end
    prev_rdata <= o_rdata;
    prev_bresp <= o_bresp;
  end

  always @(posedge i_aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Protocol and data checks
  // --------------------------------------------------
  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (o_rvalid && !i_rready) |=> o_rvalid)
    else begin
      $display("o_rvalid dropped before the R beat was accepted");
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (o_rvalid && !i_rready) |=> (o_rdata == prev_rdata))
    else begin
      $display("FAIL o_rdata got %h exp %h", $sampled(o_rdata), $sampled(prev_rdata));
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (o_bvalid && !i_bready) |=> o_bvalid)
    else begin
      $display("o_bvalid dropped before the B beat was accepted");
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (o_bvalid && !i_bready) |=> (o_bresp == prev_bresp))
    else begin
      $display("FAIL o_bresp got %h exp %h", $sampled(o_bresp), $sampled(prev_bresp));
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (o_rvalid && i_rready) |-> (o_rlast == exp_rlast))
    else begin
      $display("FAIL o_rlast got %h exp %h", $sampled(o_rlast), $sampled(exp_rlast));
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid |-> (o_rid == exp_rid))
    else begin
      $display("FAIL o_rid got %h exp %h", $sampled(o_rid), $sampled(exp_rid));
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid |-> (o_bid == exp_bid))
    else begin
      $display("FAIL o_bid got %h exp %h", $sampled(o_bid), $sampled(exp_bid));
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (o_rvalid && i_rready) |-> (o_rdata == exp_rdata))
    else begin
      $display("FAIL o_rdata got %h exp %h", $sampled(o_rdata), $sampled(exp_rdata));
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (o_rvalid && i_rready) |-> (o_rresp == exp_rresp))
    else begin
      $display("FAIL o_rresp got %h exp %h", $sampled(o_rresp), $sampled(exp_rresp));
      err_cnt++;
    end

  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid |-> (o_bresp == exp_bresp))
    else begin
      $display("FAIL o_bresp got %h exp %h", $sampled(o_bresp), $sampled(exp_bresp));
      err_cnt++;
    end

  // --------------------------------------------------
  // Model and bus tasks
  // --------------------------------------------------
  task automatic model_write(input int word, input logic [`AXI_DATA_W-1:0] data,
                             input logic [`AXI_STRB_W-1:0] strb);
    for (int b = 0; b < `AXI_STRB_W; b++) begin
      if (strb[3'(b)]) begin
        model_mem[MODEL_AW'(word * `AXI_STRB_W + b)] = 8'(data >> (8 * b));
      end
    end
  endtask

  function automatic logic [`AXI_DATA_W-1:0] model_read(input int word);
    logic [`AXI_DATA_W-1:0] val;
    val = '0;
    for (int b = 0; b < `AXI_STRB_W; b++) begin
      val = val | (`AXI_DATA_W'(model_mem[MODEL_AW'(word * `AXI_STRB_W + b)]) << (8 * b));
    end
    return val;
  endfunction

  task automatic check_level(input string name, input logic got, input logic exp);
    assert (got === exp)
      else begin
        $display("FAIL %s got %h exp %h", name, got, exp);
        err_cnt++;
      end
  endtask

  task automatic fill_wr(input int nbeats, input bit rand_strb);
    for (int i = 0; i < nbeats; i++) begin
      wr_data[8'(i)] = {$urandom, $urandom};
      wr_strb[8'(i)] = rand_strb ? `AXI_STRB_W'($urandom) : {`AXI_STRB_W{1'b1}};
    end
  endtask

  // AW, then the W beats with wlast on the last one sent, then B
  task automatic write_burst(input logic [`AXI_ID_W-1:0] id, input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [7:0] len, input logic [1:0] burst,
                             input int nbeats, input logic [1:0] resp);
    int b_start;
    int word;
    b_start   = b_seen;
    word      = int'(addr >> 3);
    exp_bid   = id;
    exp_bresp = resp;
    @(negedge i_aclk);
    i_awid    = id;
    i_awaddr  = addr;
    i_awlen   = len;
    i_awburst = burst;
    i_awvalid = 1'b1;
    #1;
    while (!o_awready) begin
      @(negedge i_aclk);
      #1;
    end
    @(posedge i_aclk);
    for (int i = 0; i < nbeats; i++) begin
      @(negedge i_aclk);
      i_awvalid = 1'b0;
      // ID on the bus no longer matches once the address is taken
      i_awid    = ~id;
      i_wdata   = wr_data[8'(i)];
      i_wstrb   = wr_strb[8'(i)];
      i_wlast   = (i == nbeats - 1);
      i_wvalid  = 1'b1;
      #1;
      while (!o_wready) begin
        @(negedge i_aclk);
        #1;
      end
      @(posedge i_aclk);
    end
    @(negedge i_aclk);
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
    while (b_seen == b_start) begin
      i_bready = rand_ready ? (($urandom % 3) != 0) : 1'b1;
      @(negedge i_aclk);
    end
    i_bready = 1'b1;
    if (resp == RESP_OKAY) begin
      for (int i = 0; i < nbeats; i++) begin
        model_write((burst == BURST_INCR) ? word + i : word, wr_data[8'(i)], wr_strb[8'(i)]);
      end
    end
  endtask

  task automatic read_burst(input logic [`AXI_ID_W-1:0] id, input logic [`AXI_ADDR_W-1:0] addr,
                            input logic [7:0] len, input logic [1:0] burst,
                            input logic [1:0] resp);
    int word;
    word = int'(addr >> 3);
    for (int i = 0; i <= int'(len); i++) begin
      if (resp != RESP_OKAY) begin
        exp_r_data[8'(i)] = '0;
      end else begin
        exp_r_data[8'(i)] = model_read((burst == BURST_INCR) ? word + i : word);
      end
    end
    exp_rid   = id;
    exp_rresp = resp;
    r_len     = int'(len);
    r_base    = r_seen;
    @(negedge i_aclk);
    i_arid    = id;
    i_araddr  = addr;
    i_arlen   = len;
    i_arburst = burst;
    i_arvalid = 1'b1;
    #1;
    while (!o_arready) begin
      @(negedge i_aclk);
      #1;
    end
    @(posedge i_aclk);
    @(negedge i_aclk);
    i_arvalid = 1'b0;
    i_arid    = ~id;
    while ((r_seen - r_base) <= r_len) begin
      i_rready = rand_ready ? (($urandom % 4) != 0) : 1'b1;
      @(negedge i_aclk);
    end
    i_rready = 1'b1;
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == err_at_start) begin
      $display("Test %0d %s: passed", test_cnt, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - err_at_start);
    end
    err_at_start = err_cnt;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(31819));
    i_rst_n   = 1'b0;
    {i_awid, i_awaddr, i_awlen, i_awburst, i_awvalid} = '0;
    {i_arid, i_araddr, i_arlen, i_arburst, i_arvalid} = '0;
    {i_awlock, i_awcache, i_awprot, i_arlock, i_arcache, i_arprot} = '0;
    i_awsize  = 3'd3;
    i_arsize  = 3'd3;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wlast   = 1'b0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b1;
    i_rready  = 1'b1;
    repeat (4) @(negedge i_aclk);
    i_rst_n = 1'b1;

    @(negedge i_aclk);
    check_level("o_awready", o_awready, 1'b1);
    check_level("o_arready", o_arready, 1'b1);
    check_level("o_wready", o_wready, 1'b0);
    check_level("o_bvalid", o_bvalid, 1'b0);
    check_level("o_rvalid", o_rvalid, 1'b0);
    report_test("reset state");

    fill_wr(1, 1'b0);
    write_burst(4'h3, 32'h20, 8'd0, BURST_INCR, 1, RESP_OKAY);
    fill_wr(1, 1'b1);
    if (wr_strb[0] == '0 || wr_strb[0] == '1) begin
      wr_strb[0] = 8'h3C;
    end
    write_burst(4'h5, 32'h20, 8'd0, BURST_INCR, 1, RESP_OKAY);
    read_burst(4'h9, 32'h20, 8'd0, BURST_INCR, RESP_OKAY);
    report_test("single beat strobe merge");

    rand_ready = 1'b1;
    fill_wr(8, 1'b0);
    write_burst(4'h1, 32'h80, 8'd7, BURST_INCR, 8, RESP_OKAY);
    read_burst(4'hA, 32'h80, 8'd7, BURST_INCR, RESP_OKAY);
    rand_ready = 1'b0;
    report_test("incr burst with back-pressure");

    fill_wr(4, 1'b0);
    write_burst(4'h2, 32'h140, 8'd3, BURST_FIXED, 4, RESP_OKAY);
    read_burst(4'hB, 32'h140, 8'd2, BURST_FIXED, RESP_OKAY);
    report_test("fixed bursts");

    // Word 0 shares its index bits with the out-of-range address
    fill_wr(1, 1'b0);
    write_burst(4'h4, 32'h0, 8'd0, BURST_INCR, 1, RESP_OKAY);
    fill_wr(2, 1'b0);
    write_burst(4'h6, 32'h2000, 8'd1, BURST_INCR, 2, RESP_SLVERR);
    read_burst(4'hC, 32'h2000, 8'd1, BURST_INCR, RESP_SLVERR);
    read_burst(4'hD, 32'h0, 8'd0, BURST_INCR, RESP_OKAY);
    report_test("out of range address");

    fill_wr(4, 1'b0);
    write_burst(4'h7, 32'h180, 8'd3, BURST_INCR, 4, RESP_OKAY);
    fill_wr(4, 1'b0);
    write_burst(4'h8, 32'h180, 8'd3, BURST_WRAP, 4, RESP_SLVERR);
    read_burst(4'hE, 32'h180, 8'd3, BURST_WRAP, RESP_SLVERR);
    read_burst(4'hF, 32'h180, 8'd3, BURST_INCR, RESP_OKAY);
    report_test("wrap burst");

    fill_wr(1, 1'b0);
    write_burst(4'h9, 32'h1C0, 8'd0, BURST_INCR, 1, RESP_OKAY);
    fill_wr(1, 1'b0);
    write_burst(4'hA, 32'h1C0, 8'd3, BURST_INCR, 1, RESP_SLVERR);
    read_burst(4'h1, 32'h1C0, 8'd0, BURST_INCR, RESP_OKAY);
    report_test("early wlast");

    fill_wr(4, 1'b0);
    fork
      write_burst(4'hB, 32'h200, 8'd3, BURST_INCR, 4, RESP_OKAY);
      read_burst(4'h2, 32'h80, 8'd7, BURST_INCR, RESP_OKAY);
    join
    read_burst(4'h3, 32'h200, 8'd3, BURST_INCR, RESP_OKAY);
    report_test("concurrent read and write");

    $display("Tests: %0d, failed tests: %0d, errors: %0d", test_cnt, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
